//--- rtl/cpu_pkg.sv
package cpu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Core widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int data_w    = 16;
    localparam int reg_sel_w = 2;
    localparam int num_regs  = 2 ** reg_sel_w;
    localparam int pc_w      = 8;
    localparam int op_w      = 4;
    localparam int imm_w     = 8;

    // Shift amount comes from the low bits of operand b
    localparam int shamt_w   = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int op_msb  = 15;
    localparam int op_lsb  = 12;
    localparam int rd_msb  = 11;
    localparam int rd_lsb  = 10;
    localparam int rs1_msb = 9;
    localparam int rs1_lsb = 8;
    localparam int rs2_msb = 7;
    localparam int rs2_lsb = 6;
    // imm8 overlaps rs2, only LDI, JMP and BNZ use it
    localparam int imm_msb = 7;
    localparam int imm_lsb = 0;

    // Codes 11 to 14 are not listed and run as NOP
    typedef enum logic [op_w-1:0] {
        ADD    = 4'h0,
        SUB    = 4'h1,
        AND_OP = 4'h2,
        OR_OP  = 4'h3,
        XOR_OP = 4'h4,
        SHL    = 4'h5,
        SHR    = 4'h6,
        LDI    = 4'h7,
        OUT    = 4'h8,
        JMP    = 4'h9,
        BNZ    = 4'ha,
        HALT   = 4'hf
    } opcode_t;

    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        DECODE  = 2'd1,
        EXECUTE = 2'd2
    } state_t;

endpackage

//--- rtl/rf_if.sv
`timescale 1ns/1ps

interface rf_if;
    import cpu_pkg::*;

    // Read side
    logic [reg_sel_w-1:0] read_sel1;
    logic [reg_sel_w-1:0] read_sel2;
    logic                 read_en;
    logic [data_w-1:0]    read_out1;
    logic [data_w-1:0]    read_out2;

    // Write side
    logic [reg_sel_w-1:0] write_sel;
    logic [data_w-1:0]    write_data;
    logic                 write_en;

    modport ctrl (
        output read_sel1, read_sel2, read_en,
        output write_sel, write_data, write_en,
        input  read_out1, read_out2
    );

    modport rf (
        input  read_sel1, read_sel2, read_en,
        input  write_sel, write_data, write_en,
        output read_out1, read_out2
    );

endinterface

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic clk,
    input  logic reset_n,
    rf_if.rf     rf
);
    import cpu_pkg::*;

    logic [data_w-1:0] regs [num_regs];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // All four entries are general purpose, r0 included
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.write_en) begin
            regs[rf.write_sel] <= rf.write_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs hold between decodes, so operands stay
    // stable through the whole execute cycle
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rf.read_out1 <= '0;
            rf.read_out2 <= '0;
        end else if (rf.read_en) begin
            rf.read_out1 <= regs[rf.read_sel1];
            rf.read_out2 <= regs[rf.read_sel2];
        end
    end

    // Decode and write-back belong to different states of the controller
    a_no_read_write_overlap: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(rf.read_en && rf.write_en)
    );

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::data_w-1:0] a,
    input  logic [cpu_pkg::data_w-1:0] b,
    input  cpu_pkg::opcode_t           op,
    output logic [cpu_pkg::data_w-1:0] result
);
    import cpu_pkg::*;

    logic [shamt_w-1:0] shamt;

    // Upper bits of b are ignored for shifts
    assign shamt = b[shamt_w-1:0];

    // Add and subtract wrap at the word width
    always_comb begin
        case (op)
            ADD: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            AND_OP: begin
                result = a & b;
            end
            OR_OP: begin
                result = a | b;
            end
            XOR_OP: begin
                result = a ^ b;
            end
            SHL: begin
                result = a << shamt;
            end
            SHR: begin
                result = a >> shamt;
            end
            // Non-ALU opcodes pass operand a
            default: begin
                result = a;
            end
        endcase
    end

endmodule

//--- rtl/control_fsm.sv
`timescale 1ns/1ps

module control_fsm (
    input  logic                       clk,
    input  logic                       reset_n,
    output logic [cpu_pkg::pc_w-1:0]   imem_addr,
    input  logic [cpu_pkg::data_w-1:0] imem_data,
    rf_if.ctrl                         rf,
    output cpu_pkg::opcode_t           alu_op,
    input  logic [cpu_pkg::data_w-1:0] alu_result,
    output logic [cpu_pkg::data_w-1:0] out_data,
    output logic                       out_valid,
    output logic                       halted
);
    import cpu_pkg::*;

    state_t            state;
    state_t            state_nxt;
    logic [pc_w-1:0]   pc;
    logic [pc_w-1:0]   pc_nxt;
    logic [pc_w-1:0]   pc_inc;
    logic [data_w-1:0] ir;
    logic              halt_flag;
    opcode_t           opcode;
    logic [imm_w-1:0]  imm8;
    logic              writes_rd;
    logic              is_halt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign opcode = opcode_t'(ir[op_msb:op_lsb]);
    assign imm8   = ir[imm_msb:imm_lsb];
    assign pc_inc = pc + 1'b1;
    assign is_halt = halt_flag || (opcode == HALT);

    assign imem_addr = pc;
    assign alu_op    = opcode;

    assign rf.read_sel1 = ir[rs1_msb:rs1_lsb];
    assign rf.read_sel2 = ir[rs2_msb:rs2_lsb];
    assign rf.read_en   = (state == DECODE);
    assign rf.write_sel = ir[rd_msb:rd_lsb];

    // Only ALU ops and LDI write back
    always_comb begin
        case (opcode)
            ADD, SUB, AND_OP, OR_OP, XOR_OP, SHL, SHR, LDI: begin
                writes_rd = 1'b1;
            end
            default: begin
                writes_rd = 1'b0;
            end
        endcase
    end

    assign rf.write_en   = (state == EXECUTE) && writes_rd;
    assign rf.write_data = (opcode == LDI) ? {{(data_w-imm_w){1'b0}}, imm8} : alu_result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencing and branch resolution
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_nxt = state;
        pc_nxt    = pc;
        case (state)
            FETCH: begin
                state_nxt = DECODE;
            end
            DECODE: begin
                state_nxt = EXECUTE;
            end
            EXECUTE: begin
                // HALT parks here until reset
                if (!is_halt) begin
                    state_nxt = FETCH;
                    case (opcode)
                        JMP: begin
                            pc_nxt = pc_w'(imm8);
                        end
                        BNZ: begin
                            pc_nxt = (rf.read_out1 != '0) ? pc_w'(imm8) : pc_inc;
                        end
                        default: begin
                            pc_nxt = pc_inc;
                        end
                    endcase
                end
            end
            default: begin
                state_nxt = FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= FETCH;
            pc        <= '0;
            halt_flag <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            pc    <= pc_nxt;
            if ((state == EXECUTE) && is_halt) begin
                halt_flag <= 1'b1;
            end
            // Pulse lines up with the execute cycle of OUT
            out_valid <= (state == DECODE) && (opcode == OUT);
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            ir <= imem_data;
        end
    end

    // read_out1 only moves in decode, so it is stable for the pulse
    assign out_data = rf.read_out1;
    assign halted   = halt_flag || ((state == EXECUTE) && (opcode == HALT));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_out_in_execute: assert property (
        @(posedge clk) disable iff (!reset_n)
        out_valid |-> (state == EXECUTE)
    );

    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!reset_n)
        (halted && reset_n) |=> halted
    );

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                       clk,
    input  logic                       reset_n,
    output logic [cpu_pkg::pc_w-1:0]   imem_addr,
    input  logic [cpu_pkg::data_w-1:0] imem_data,
    output logic [cpu_pkg::data_w-1:0] out_data,
    output logic                       out_valid,
    output logic                       halted
);
    import cpu_pkg::*;

    opcode_t           alu_op;
    logic [data_w-1:0] alu_result;

    rf_if i_rf_if ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    register_file i_register_file (
        .clk     (clk),
        .reset_n (reset_n),
        .rf      (i_rf_if.rf)
    );

    // Operands come straight from the registered read ports
    alu i_alu (
        .a      (i_rf_if.read_out1),
        .b      (i_rf_if.read_out2),
        .op     (alu_op),
        .result (alu_result)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    control_fsm i_control_fsm (
        .clk        (clk),
        .reset_n    (reset_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .rf         (i_rf_if.ctrl),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .halted     (halted)
    );

endmodule

//--- verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 10;
    localparam int drain_cycles = 20;
    localparam int max_steps    = 256;
    localparam int num_programs = 10;
    localparam int imem_depth   = 2 ** pc_w;
    localparam int loop_count   = 5;
    localparam longint watchdog_limit =
        longint'(num_programs) * (max_steps * 3 + reset_cycles + drain_cycles + 4) * clk_period;

    logic              clk;
    logic              reset_n;
    logic [pc_w-1:0]   imem_addr;
    logic [data_w-1:0] imem_data;
    logic [data_w-1:0] out_data;
    logic              out_valid;
    logic              halted;

    logic [data_w-1:0] imem [imem_depth];

    integer            seed = 67753;
    int                err_count;
    logic [data_w-1:0] exp_vals [$];
    int                exp_cycles [$];
    int                exp_count;
    int                exp_halt_cycle;
    int                cycle_cnt;
    int                n_out;
    bit                halt_seen;

    // Instruction memory answers in the same cycle
    assign imem_data = imem[imem_addr];

    cpu_top i_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            err_count++;
            $display("ERR time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(string reason);
        err_count++;
        $display("Error at %0t: %s", $time, reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic int unsigned pick(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [data_w-1:0] encode(logic [op_w-1:0] op, int unsigned rd,
                                                 int unsigned rs1, int unsigned low8);
        return {op, rd[reg_sel_w-1:0], rs1[reg_sel_w-1:0], low8[imm_w-1:0]};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Programs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Unused words are HALT with their own address in the immediate
    task automatic fill_memory();
        for (int i = 0; i < imem_depth; i++) begin
            imem[i] = encode(HALT, 0, 0, i);
        end
    endtask

    task automatic load_output_program();
        fill_memory();
        imem[0] = encode(LDI, 0, 0, 8'h5a);
        imem[1] = encode(LDI, 1, 0, 8'ha5);
        imem[2] = encode(LDI, 2, 0, 8'h3c);
        imem[3] = encode(LDI, 3, 0, 8'hff);
        for (int i = 0; i < num_regs; i++) begin
            imem[4 + i] = encode(OUT, 0, i, 0);
        end
        imem[8] = encode(HALT, 0, 0, 0);
    endtask

    // Countdown in r1 by r2, then a JMP over one OUT
    task automatic loop_program();
        fill_memory();
        imem[0] = encode(LDI, 1, 0, loop_count);
        imem[1] = encode(LDI, 2, 0, 1);
        imem[2] = encode(OUT, 0, 1, 0);
        imem[3] = encode(SUB, 1, 1, 2 << rs2_lsb);
        imem[4] = encode(BNZ, 0, 1, 2);
        imem[5] = encode(JMP, 0, 0, 7);
        imem[6] = encode(OUT, 0, 2, 0);
        imem[7] = encode(OUT, 0, 1, 0);
        imem[8] = encode(HALT, 0, 0, 0);
    endtask

    task automatic random_program();
        int unsigned len;
        int unsigned op_idx;
        int unsigned low8;
        fill_memory();
        len = 8 + pick(41);
        // Give every register random contents first
        for (int i = 0; i < num_regs; i++) begin
            imem[i] = encode(LDI, i, 0, pick(256));
        end
        for (int unsigned addr = num_regs; addr < len - 1; addr++) begin
            op_idx = pick(11);
            low8   = pick(256);
            // Branch targets only move forward
            if (op_idx == JMP || op_idx == BNZ) begin
                low8 = addr + 1 + pick(len - 1 - addr);
            end
            imem[addr] = encode(op_idx[op_w-1:0], pick(4), pick(4), low8);
        end
        imem[len - 1] = encode(HALT, 0, 0, 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ISA reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_model();
        logic [data_w-1:0] regs [num_regs];
        logic [pc_w-1:0]   pc;
        logic [pc_w-1:0]   pc_next;
        logic [data_w-1:0] instr;
        logic [op_w-1:0]   op;
        logic [1:0]        rd;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        int                step;
        bit                done;
        exp_vals.delete();
        exp_cycles.delete();
        for (int i = 0; i < num_regs; i++) begin
            regs[i] = '0;
        end
        pc   = '0;
        step = 0;
        done = 1'b0;
        while (!done) begin
            if (step >= max_steps) begin
                abort_run("reference model reached the step limit without a HALT");
            end
            instr   = imem[pc];
            op      = instr[op_msb:op_lsb];
            rd      = instr[rd_msb:rd_lsb];
            a       = regs[instr[rs1_msb:rs1_lsb]];
            b       = regs[instr[rs2_msb:rs2_lsb]];
            pc_next = pc + 1'b1;
            case (op)
                ADD:    regs[rd] = a + b;
                SUB:    regs[rd] = a - b;
                AND_OP: regs[rd] = a & b;
                OR_OP:  regs[rd] = a | b;
                XOR_OP: regs[rd] = a ^ b;
                SHL:    regs[rd] = a << b[3:0];
                SHR:    regs[rd] = a >> b[3:0];
                LDI:    regs[rd] = {8'h00, instr[7:0]};
                OUT: begin
                    exp_vals.push_back(a);
                    exp_cycles.push_back(3 * step + 2);
                end
                JMP:    pc_next = instr[7:0];
                BNZ: begin
                    if (a != '0) begin
                        pc_next = instr[7:0];
                    end
                end
                HALT: begin
                    exp_halt_cycle = 3 * step + 2;
                    done           = 1'b1;
                end
                default: pc_next = pc + 1'b1;
            endcase
            pc = pc_next;
            step++;
        end
        exp_count = exp_vals.size();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset and output monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic hold_reset();
        @(posedge clk);
        reset_n <= 1'b0;
        repeat (reset_cycles - 1) begin
            @(posedge clk);
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
            check_value("halted", halted, 0);
            check_value("imem_addr", imem_addr, 0);
        end
        @(posedge clk);
        reset_n <= 1'b1;
    endtask

    // Cycle 0 is the first cycle after reset release
    always @(negedge clk) begin
        if (!reset_n) begin
            cycle_cnt = 0;
            n_out     = 0;
            halt_seen = 1'b0;
        end else begin
            if (cycle_cnt == 0) begin
                check_value("imem_addr", imem_addr, 0);
            end
            if (out_valid === 1'b1) begin
                if (exp_vals.size() == 0) begin
                    abort_run("out_valid pulsed with no output left in the model");
                end else begin
                    check_value("out_data", out_data, exp_vals.pop_front());
                    check_value("out_cycle", cycle_cnt, exp_cycles.pop_front());
                    n_out++;
                end
            end
            if (halt_seen) begin
                check_value("halted", halted, 1);
            end else if (halted !== 1'b0) begin
                check_value("halt_cycle", cycle_cnt, exp_halt_cycle);
                halt_seen = 1'b1;
            end
            cycle_cnt++;
        end
    end

    initial begin
        #(watchdog_limit);
        $display("Timeout after %0d ns, the core never finished all programs", watchdog_limit);
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        $timeformat(-9, 0, " ns", 10);
        reset_n   = 1'b0;
        err_count = 0;
        fill_memory();
        for (int p = 0; p < num_programs; p++) begin
            case (p)
                0:       load_output_program();
                1:       loop_program();
                default: random_program();
            endcase
            run_model();
            hold_reset();
            while (!halt_seen) begin
                @(posedge clk);
            end
            // No output may follow HALT
            repeat (drain_cycles) @(posedge clk);
            check_value("out_count", n_out, exp_count);
        end
        if (err_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

//--- files.f
rtl/cpu_pkg.sv
rtl/rf_if.sv
rtl/register_file.sv
rtl/alu.sv
rtl/control_fsm.sv
rtl/cpu_top.sv
verification/cpu_tb.sv
